/* Bender.yml */
package:
  name: fetch_front

sources:
  # package first, then the stages, then the top level
  - hw/fetch_pkg.sv
  - hw/pre_if_stage.sv
  - hw/branch_target_buffer.sv
  - hw/if_stage.sv
  - hw/fetch_front.sv
  - target: simulation
    files:
      - testbench/fetch_front_tb.sv

/* flist.f */
hw/fetch_pkg.sv
hw/pre_if_stage.sv
hw/branch_target_buffer.sv
hw/if_stage.sv
hw/fetch_front.sv
testbench/fetch_front_tb.sv

/* hw/branch_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [31:0]                lookup_pc,
    input  wire fetch_pkg::br_bus_t   br_bus,
    output fetch_pkg::bpu_pred_t      pred
);

    typedef struct packed {
        logic [fetch_pkg::btb_tag_bits-1:0] tag;
        logic [31:0]                        target;
    } btb_line_t;

    logic [fetch_pkg::btb_entries-1:0]   valid_q;
    btb_line_t                           lines_q [fetch_pkg::btb_entries];

    logic [fetch_pkg::btb_index_bits-1:0] rd_index;
    logic [fetch_pkg::btb_tag_bits-1:0]   rd_tag;
    btb_line_t                            rd_line;

    logic [fetch_pkg::btb_index_bits-1:0] wr_index;
    logic [fetch_pkg::btb_tag_bits-1:0]   wr_tag;
    logic                                 wr_en;
    logic                                 clr_en;

    // lookup in the same cycle as the pre-fetch pc
    assign rd_index = lookup_pc[fetch_pkg::btb_index_bits+1:2];
    assign rd_tag   = lookup_pc[31:fetch_pkg::btb_index_bits+2];
    assign rd_line  = lines_q[rd_index];

    always_comb begin
        pred.valid  = valid_q[rd_index] & (rd_line.tag == rd_tag);
        pred.target = rd_line.target;
    end

    // update from the branch in execute
    assign wr_index = br_bus.branch_pc[fetch_pkg::btb_index_bits+1:2];
    assign wr_tag   = br_bus.branch_pc[31:fetch_pkg::btb_index_bits+2];
    assign wr_en    = br_bus.is_branch & br_bus.taken;

    // stale entry when predicted taken but fell through
    assign clr_en = br_bus.is_branch & br_bus.pred_valid & ~br_bus.taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;
        end else if (clr_en) begin
            valid_q[wr_index] <= 1'b0;
        end
    end

    // tag and target of the entry a taken branch writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines_q[wr_index].tag    <= wr_tag;
            lines_q[wr_index].target <= br_bus.target;
        end
    end

    // execute must only report taken or predicted outcomes for real branches
    no_write_without_branch: assert property (
        @(posedge clk) disable iff (reset)
        (br_bus.taken | br_bus.pred_valid) |-> br_bus.is_branch
    ) else $error("btb update requested with is_branch low");

endmodule

`default_nettype wire

/* hw/fetch_front.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front (
    input  wire                       clk,
    input  wire                       reset,
    input  wire fetch_pkg::br_bus_t   br_bus,
    input  wire fetch_pkg::redirect_t redirect,
    input  wire                       icache_busy,
    input  wire                       icache_rvalid,
    input  wire [31:0]                icache_rdata,
    input  wire                       ds_allowin,
    output fetch_pkg::icache_req_t    icache_req,
    output fetch_pkg::fs_to_ds_t      fs_to_ds,
    output logic                      fs_to_ds_valid
);

    logic [31:0]          lookup_pc;
    fetch_pkg::bpu_pred_t pred;
    fetch_pkg::ps_to_fs_t ps_to_fs;
    logic                 ps_to_fs_valid;
    logic                 fs_allowin;

    // pc generation, translation and cache request
    pre_if_stage u_pre_if (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .redirect       (redirect),
        .pred           (pred),
        .fs_allowin     (fs_allowin),
        .icache_busy    (icache_busy),
        .lookup_pc      (lookup_pc),
        .icache_req     (icache_req),
        .ps_to_fs       (ps_to_fs),
        .ps_to_fs_valid (ps_to_fs_valid)
    );

    // trained from execute, read with the current pc
    branch_target_buffer u_btb (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (lookup_pc),
        .br_bus    (br_bus),
        .pred      (pred)
    );

    // pairs the cache word with its pc
    if_stage u_if (
        .clk            (clk),
        .reset          (reset),
        .redirect       (redirect),
        .ps_to_fs       (ps_to_fs),
        .ps_to_fs_valid (ps_to_fs_valid),
        .icache_rvalid  (icache_rvalid),
        .icache_rdata   (icache_rdata),
        .ds_allowin     (ds_allowin),
        .fs_allowin     (fs_allowin),
        .fs_to_ds       (fs_to_ds),
        .fs_to_ds_valid (fs_to_ds_valid)
    );

endmodule

`default_nettype wire

/* hw/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // boot and exception vectors
    localparam logic [31:0] reset_pc      = 32'hbfc0_0000;
    localparam logic [31:0] general_ex_pc = 32'hbfc0_0380;

    // cp0 exception codes seen by fetch
    localparam logic [4:0] exc_none = 5'd0;
    localparam logic [4:0] exc_adel = 5'd4;

    // branch target buffer geometry
    localparam int btb_index_bits = 4;
    localparam int btb_entries    = 1 << btb_index_bits;
    localparam int btb_tag_bits   = 32 - btb_index_bits - 2;

    // branch resolution from execute
    typedef struct packed {
        logic        pred_valid;
        logic        is_branch;
        logic        taken;
        logic        pred_right;
        logic [31:0] target;
        logic [31:0] branch_pc;
    } br_bus_t;

    // redirects from writeback and exception logic
    typedef struct packed {
        logic        flush;
        logic        eret;
        logic        br_flush;
        logic [31:0] epc;
    } redirect_t;

    // instruction cache request with physical tag and virtual index
    typedef struct packed {
        logic        valid;
        logic [7:0]  index;
        logic [19:0] tag;
        logic [3:0]  offset;
    } icache_req_t;

    typedef struct packed {
        logic        valid_end;
        logic [31:0] pc;
        logic        ex;
        logic [4:0]  exccode;
    } ps_to_fs_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } bpu_pred_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        ex;
        logic [4:0]  exccode;
    } fs_to_ds_t;

endpackage

`default_nettype wire

/* hw/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire fetch_pkg::redirect_t redirect,
    input  wire fetch_pkg::ps_to_fs_t ps_to_fs,
    input  wire                       ps_to_fs_valid,
    input  wire                       icache_rvalid,
    input  wire [31:0]                icache_rdata,
    input  wire                       ds_allowin,
    output logic                      fs_allowin,
    output fetch_pkg::fs_to_ds_t      fs_to_ds,
    output logic                      fs_to_ds_valid
);

    fetch_pkg::ps_to_fs_t entry_q;
    logic                 full_q;
    logic                 has_word_q;
    logic                 drop_word_q;
    logic [31:0]          inst_q;

    logic                 redirect_go;
    logic                 waiting;
    logic                 word_in;
    logic                 ready;
    logic                 leave;
    logic                 ps_in;

    assign redirect_go = redirect.flush | redirect.eret;

    // entry with an exception never waits on the cache
    assign waiting = full_q & ~entry_q.ex & ~has_word_q;
    assign word_in = waiting & icache_rvalid & ~drop_word_q;
    assign ready   = full_q & (entry_q.ex | has_word_q | word_in);

    // dead slot leaves without a decode handshake
    assign leave      = ready & (ds_allowin | ~entry_q.valid_end);
    assign fs_allowin = ~full_q | leave;
    assign ps_in      = ps_to_fs_valid & fs_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q      <= 1'b0;
            has_word_q  <= 1'b0;
            drop_word_q <= 1'b0;
        end else if (redirect_go) begin
            full_q     <= 1'b0;
            has_word_q <= 1'b0;
            // request issued in the redirect cycle still returns a word
            drop_word_q <= ps_to_fs_valid & ~ps_to_fs.ex;
        end else begin
            drop_word_q <= 1'b0;
            if (ps_in) begin
                full_q     <= 1'b1;
                has_word_q <= 1'b0;
            end else if (leave) begin
                full_q     <= 1'b0;
                has_word_q <= 1'b0;
            end else if (word_in) begin
                has_word_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ps_in) begin
            entry_q <= ps_to_fs;
        end
        if (word_in) begin
            inst_q <= icache_rdata;
        end
    end

    // word is bypassed in its return cycle, held after that
    always_comb begin
        fs_to_ds.pc      = entry_q.pc;
        fs_to_ds.inst    = entry_q.ex ? 32'd0 : (has_word_q ? inst_q : icache_rdata);
        fs_to_ds.ex      = entry_q.ex;
        fs_to_ds.exccode = entry_q.exccode;
    end

    assign fs_to_ds_valid = ready & entry_q.valid_end;

    // every returned word belongs to a held entry or to a discarded request
    rvalid_has_owner: assert property (
        @(posedge clk) disable iff (reset)
        icache_rvalid |-> (waiting | drop_word_q)
    ) else $error("icache word returned with no request outstanding");

endmodule

`default_nettype wire

/* hw/pre_if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pre_if_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire fetch_pkg::br_bus_t   br_bus,
    input  wire fetch_pkg::redirect_t redirect,
    input  wire fetch_pkg::bpu_pred_t pred,
    input  wire                       fs_allowin,
    input  wire                       icache_busy,
    output logic [31:0]               lookup_pc,
    output fetch_pkg::icache_req_t    icache_req,
    output fetch_pkg::ps_to_fs_t      ps_to_fs,
    output logic                      ps_to_fs_valid
);

    logic [31:0] pc_q;
    logic [31:0] next_pc;
    logic [31:0] seq_pc;
    logic [31:0] right_flow_pc;
    logic [31:0] wrong_flow_pc;
    logic        flush_delayed_q;
    logic        redirect_go;
    logic        ps_allowin;
    logic        pc_load;
    logic        fetch_go;
    logic        misaligned;
    logic        kseg_unmapped;
    logic [19:0] phys_page;

    // eret and flush both steer the pc and empty the pipe
    assign redirect_go = redirect.flush | redirect.eret;
    assign ps_allowin  = redirect_go | fs_allowin;
    assign pc_load     = redirect_go | (~icache_busy & fs_allowin);

    assign seq_pc        = pc_q + 32'd4;
    assign right_flow_pc = pred.valid ? pred.target : seq_pc;
    assign wrong_flow_pc = br_bus.taken ? br_bus.target : br_bus.branch_pc + 32'd8;

    // next pc priority
    always_comb begin
        if (redirect.eret) begin
            next_pc = redirect.epc;
        end else if (redirect.flush) begin
            next_pc = fetch_pkg::general_ex_pc;
        end else if (br_bus.is_branch) begin
            if (br_bus.pred_valid) begin
                next_pc = br_bus.pred_right ? right_flow_pc : wrong_flow_pc;
            end else if (br_bus.taken) begin
                next_pc = br_bus.target;
            end else begin
                next_pc = right_flow_pc;
            end
        end else begin
            next_pc = right_flow_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= fetch_pkg::reset_pc;
        end else if (pc_load) begin
            pc_q <= next_pc;
        end
    end

    // request for the new pc goes out on the first free cycle after a redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_delayed_q <= 1'b0;
        end else if (redirect_go) begin
            flush_delayed_q <= 1'b1;
        end else if (~icache_busy) begin
            flush_delayed_q <= 1'b0;
        end
    end

    assign fetch_go   = ~icache_busy & (flush_delayed_q | ps_allowin);
    assign misaligned = pc_q[1:0] != 2'b00;

    // fixed mapping where kseg0 and kseg1 drop the segment bits
    assign kseg_unmapped = pc_q[31:30] == 2'b10;
    assign phys_page     = kseg_unmapped ? {3'b000, pc_q[28:12]} : pc_q[31:12];

    assign lookup_pc = pc_q;

    always_comb begin
        icache_req.valid  = fetch_go & ~misaligned;
        icache_req.index  = pc_q[11:4];
        icache_req.tag    = phys_page;
        icache_req.offset = pc_q[3:0];
    end

    // delay slot successor is marked dead on a branch flush
    always_comb begin
        ps_to_fs.valid_end = fetch_go & ~redirect.br_flush;
        ps_to_fs.pc        = pc_q;
        ps_to_fs.ex        = misaligned;
        ps_to_fs.exccode   = misaligned ? fetch_pkg::exc_adel : fetch_pkg::exc_none;
    end

    assign ps_to_fs_valid = ~icache_busy;

endmodule

`default_nettype wire

/* testbench/fetch_front_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front_tb;

    localparam int trace_fields = 20;
    localparam int max_lines    = 64;
    localparam int clk_period   = 8;

    logic                   clk = 1'b0;
    logic                   reset;
    fetch_pkg::br_bus_t     br_bus;
    fetch_pkg::redirect_t   redirect;
    logic                   icache_busy;
    logic                   icache_rvalid;
    logic [31:0]            icache_rdata;
    logic                   ds_allowin;
    fetch_pkg::icache_req_t icache_req;
    fetch_pkg::fs_to_ds_t   fs_to_ds;
    logic                   fs_to_ds_valid;

    logic [31:0] trace_mem [trace_fields*max_lines];
    int          line_count = 0;

    // cache model holds at most one word in flight
    logic        word_pending;
    logic [31:0] pending_word;

    fetch_front uut (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .redirect       (redirect),
        .icache_busy    (icache_busy),
        .icache_rvalid  (icache_rvalid),
        .icache_rdata   (icache_rdata),
        .ds_allowin     (ds_allowin),
        .icache_req     (icache_req),
        .fs_to_ds       (fs_to_ds),
        .fs_to_ds_valid (fs_to_ds_valid)
    );

    always #(clk_period/2) clk = ~clk;

    function automatic string test_name(input logic [31:0] id);
        case (id)
            1: return "sequential_fetch";
            2: return "busy_backpressure";
            3: return "btb_prediction";
            4: return "flush_eret";
            5: return "misaligned_translation";
            6: return "delay_slot_squash";
            default: return "unknown";
        endcase
    endfunction

    // kseg0 and kseg1 both map onto the first 512 MB of physical memory
    function automatic fetch_pkg::icache_req_t expected_req(input logic valid,
                                                            input logic [31:0] pc);
        logic [31:0]            phys;
        fetch_pkg::icache_req_t req;
        if (pc >= 32'ha000_0000 && pc < 32'hc000_0000) begin
            phys = pc - 32'ha000_0000;
        end else if (pc >= 32'h8000_0000 && pc < 32'ha000_0000) begin
            phys = pc - 32'h8000_0000;
        end else begin
            phys = pc;
        end
        req.valid  = valid;
        req.index  = phys[11:4];
        req.tag    = phys[31:12];
        req.offset = phys[3:0];
        return req;
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_req(input string name, input fetch_pkg::icache_req_t exp,
                             input fetch_pkg::icache_req_t act);
        if (act !== exp) begin
            $display("Mismatch %s icache_req expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s fs_to_ds_valid expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_fetch(input string name, input fetch_pkg::fs_to_ds_t exp,
                               input fetch_pkg::fs_to_ds_t act);
        if (act !== exp) begin
            $display("Mismatch %s fs_to_ds expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // a zero test id marks the end of the trace
    task automatic load_trace();
        for (int k = 0; k < trace_fields*max_lines; k++) begin
            trace_mem[k] = '0;
        end
        $readmemh("testbench/fetch_trace.txt", trace_mem);
        while (line_count < max_lines && trace_mem[line_count*trace_fields] != 0) begin
            line_count++;
        end
    endtask

    initial begin : run_trace
        fetch_pkg::br_bus_t     br_next;
        fetch_pkg::redirect_t   redir_next;
        fetch_pkg::icache_req_t exp_req;
        fetch_pkg::fs_to_ds_t   exp_dec;
        int                     base;
        string                  name;
        reset         = 1'b1;
        br_bus        = '0;
        redirect      = '0;
        icache_busy   = 1'b1;
        icache_rvalid = 1'b0;
        icache_rdata  = '0;
        ds_allowin    = 1'b0;
        word_pending  = 1'b0;
        pending_word  = '0;
        load_trace();
        if (line_count == 0) begin
            $display("trace file is missing or holds no lines");
            abort_run();
        end
        repeat (3) @(posedge clk);
        for (int i = 0; i < line_count; i++) begin
            base = i * trace_fields;
            br_next.pred_valid  = trace_mem[base+2][0];
            br_next.is_branch   = trace_mem[base+3][0];
            br_next.taken       = trace_mem[base+4][0];
            br_next.pred_right  = trace_mem[base+5][0];
            br_next.target      = trace_mem[base+6];
            br_next.branch_pc   = trace_mem[base+7];
            redir_next.flush    = trace_mem[base+8][0];
            redir_next.eret     = trace_mem[base+9][0];
            redir_next.br_flush = trace_mem[base+10][0];
            redir_next.epc      = trace_mem[base+11];
            @(posedge clk);
            // first trace line goes in on the last reset edge
            reset         <= 1'b0;
            icache_busy   <= trace_mem[base+1][0];
            br_bus        <= br_next;
            redirect      <= redir_next;
            ds_allowin    <= trace_mem[base+12][0];
            icache_rvalid <= word_pending;
            icache_rdata  <= pending_word;
            @(negedge clk);
            name    = $sformatf("line %0d %s", i, test_name(trace_mem[base]));
            exp_req = expected_req(trace_mem[base+13][0], trace_mem[base+14]);
            check_req(name, exp_req, icache_req);
            check_valid(name, trace_mem[base+15][0], fs_to_ds_valid);
            if (trace_mem[base+15][0]) begin
                exp_dec.pc      = trace_mem[base+16];
                exp_dec.inst    = trace_mem[base+17];
                exp_dec.ex      = trace_mem[base+18][0];
                exp_dec.exccode = trace_mem[base+19][4:0];
                check_fetch(name, exp_dec, fs_to_ds);
            end
            // accepted request answers next cycle with address xor a5a5a5a5
            word_pending = icache_req.valid & ~icache_busy;
            pending_word = {icache_req.tag, icache_req.index, icache_req.offset} ^ 32'ha5a5a5a5;
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (line_count > 0);
        #((line_count + 20) * clk_period);
        $display("watchdog expired before the trace was finished");
        abort_run();
    end

endmodule

`default_nettype wire

/* testbench/fetch_trace.txt */
// id busy pv ib tk pr br_target br_pc flush eret br_flush epc ds_allowin
// req_valid req_pc dec_valid dec_pc dec_inst dec_ex dec_exccode
// cache word is the physical address xor a5a5a5a5, req_pc is the virtual pc
1 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00000 0 00000000 00000000 0 00
1 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00004 1 bfc00000 ba65a5a5 0 00
1 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00008 1 bfc00004 ba65a5a1 0 00
1 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc0000c 1 bfc00008 ba65a5ad 0 00
2 1 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc00010 1 bfc0000c ba65a5a9 0 00
2 1 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc00010 0 00000000 00000000 0 00
2 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00010 0 00000000 00000000 0 00
2 0 0 0 0 0 00000000 00000000 0 0 0 00000000 0 0 bfc00014 1 bfc00010 ba65a5b5 0 00
2 0 0 0 0 0 00000000 00000000 0 0 0 00000000 0 0 bfc00014 1 bfc00010 ba65a5b5 0 00
2 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00014 1 bfc00010 ba65a5b5 0 00
2 1 0 0 0 0 00000000 00000000 0 0 0 00000000 0 0 bfc00018 1 bfc00014 ba65a5b1 0 00
2 1 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc00018 1 bfc00014 ba65a5b1 0 00
2 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00018 0 00000000 00000000 0 00
3 0 0 1 1 0 bfc00020 bfc00024 0 0 0 00000000 1 1 bfc0001c 1 bfc00018 ba65a5bd 0 00
3 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00020 1 bfc0001c ba65a5b9 0 00
3 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00024 1 bfc00020 ba65a585 0 00
3 0 1 1 1 1 bfc00020 bfc00024 0 0 0 00000000 1 1 bfc00020 1 bfc00024 ba65a581 0 00
3 0 1 1 0 0 bfc00020 bfc00024 0 0 0 00000000 1 1 bfc00024 1 bfc00020 ba65a585 0 00
3 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc0002c 1 bfc00024 ba65a581 0 00
3 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00030 1 bfc0002c ba65a589 0 00
4 0 0 0 0 0 00000000 00000000 1 0 0 00000000 0 1 bfc00034 1 bfc00030 ba65a595 0 00
4 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00380 0 00000000 00000000 0 00
4 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00384 1 bfc00380 ba65a625 0 00
4 0 0 0 0 0 00000000 00000000 1 1 0 bfc00024 1 1 bfc00388 1 bfc00384 ba65a621 0 00
4 1 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc00024 0 00000000 00000000 0 00
4 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00024 0 00000000 00000000 0 00
4 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00028 1 bfc00024 ba65a581 0 00
4 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc0002c 1 bfc00028 ba65a58d 0 00
5 0 0 0 0 0 00000000 00000000 0 1 0 bfc00102 1 1 bfc00030 1 bfc0002c ba65a589 0 00
5 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc00102 0 00000000 00000000 0 00
5 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc00106 1 bfc00102 00000000 1 04
5 0 0 0 0 0 00000000 00000000 0 1 0 00400000 1 0 bfc0010a 1 bfc00106 00000000 1 04
5 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 00400000 0 00000000 00000000 0 00
5 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 00400004 1 00400000 a5e5a5a5 0 00
5 0 0 0 0 0 00000000 00000000 0 1 0 80001000 1 1 00400008 1 00400004 a5e5a5a1 0 00
5 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 80001000 0 00000000 00000000 0 00
5 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 80001004 1 80001000 a5a5b5a5 0 00
6 0 0 1 1 0 bfc00040 80000ffc 0 0 1 00000000 1 1 80001008 1 80001004 a5a5b5a1 0 00
6 0 0 0 0 0 00000000 00000000 0 0 0 00000000 0 1 bfc00040 0 00000000 00000000 0 00
6 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00044 1 bfc00040 ba65a5e5 0 00
6 0 0 0 0 0 00000000 00000000 0 0 0 00000000 1 1 bfc00048 1 bfc00044 ba65a5e1 0 00
6 1 0 0 0 0 00000000 00000000 0 0 0 00000000 1 0 bfc0004c 1 bfc00048 ba65a5ed 0 00
